/* flist.f */
source/ocl_cmd_pkg.sv
source/ocl_slave.sv
source/rob.sv
source/key_inst_fifo.sv
source/ocl_cmd_top.sv
verification/ocl_cmd_tb.sv

/* Makefile */
TOP := ocl_cmd_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	obj_dir/V$(TOP) | tee sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* verification/ocl_cmd_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ocl_cmd_tb;

   import ocl_cmd_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int N_OPS      = 2000;

   logic        clk;
   logic        pipe_rst_n;
   logic        awvalid;
   logic [31:0] awaddr;
   logic        awready;
   logic        wvalid;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wready;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        bready;
   logic        arvalid;
   logic [31:0] araddr;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rready;
   logic        rob_valid;
   logic [POLY_ID_WIDTH-1:0]  poly_id;
   logic [OPCODE_WIDTH-1:0]   opcode;
   logic [INTT_ID_WIDTH-1:0]  intt_id;
   logic [LWE_BIT_WIDTH-1:0]  init_value;
   logic [SUBS_WIDTH-1:0]     subs_factor;
   logic [BOUND_WIDTH-1:0]    bound1;
   logic [BOUND_WIDTH-1:0]    bound2;
   logic                      ntt_rd_finish;
   logic                      key_valid;
   logic [OPCODE_WIDTH-1:0]   key_opcode;
   logic [KEY_ADDR_WIDTH-1:0] key_base_addr;
   logic                      key_rd_finish;

   // reference model state
   cmd_word_u                rob_q [$];
   logic [POLY_ID_WIDTH-1:0] pid_q [$];
   cmd_word_u                key_q [$];
   logic [POLY_ID_WIDTH-1:0] model_pid;
   logic                     rob_ovf_m;
   logic                     key_ovf_m;
   logic                     b_pending;
   logic                     r_pending;
   logic [1:0]               exp_bresp;
   logic [31:0]              exp_rdata;
   logic [1:0]               exp_rresp;
   logic                     wr_hs;
   logic                     rd_hs;
   logic                     b_hs;
   logic                     r_hs;
   int                       pop_thresh;

   logic [BOUND_WIDTH-1:0] bound1_tab [8] = '{16'h0400, 16'h0c00, 16'h1400, 16'h1c00,
                                              16'h2400, 16'h2c00, 16'h3400, 16'h3c00};
   logic [BOUND_WIDTH-1:0] bound2_tab [8] = '{16'h4600, 16'h4e00, 16'h5600, 16'h5e00,
                                              16'h6600, 16'h6e00, 16'h7600, 16'h7e00};

   ocl_cmd_top u_dut (
      .clk           (clk),
      .pipe_rst_n    (pipe_rst_n),
      .awvalid       (awvalid),
      .awaddr        (awaddr),
      .awready       (awready),
      .wvalid        (wvalid),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .wready        (wready),
      .bvalid        (bvalid),
      .bresp         (bresp),
      .bready        (bready),
      .arvalid       (arvalid),
      .araddr        (araddr),
      .arready       (arready),
      .rvalid        (rvalid),
      .rdata         (rdata),
      .rresp         (rresp),
      .rready        (rready),
      .rob_valid     (rob_valid),
      .poly_id       (poly_id),
      .opcode        (opcode),
      .intt_id       (intt_id),
      .init_value    (init_value),
      .subs_factor   (subs_factor),
      .bound1        (bound1),
      .bound2        (bound2),
      .ntt_rd_finish (ntt_rd_finish),
      .key_valid     (key_valid),
      .key_opcode    (key_opcode),
      .key_base_addr (key_base_addr),
      .key_rd_finish (key_rd_finish)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ends a run that stops making progress
   initial
   begin
      #(N_OPS * 40 * CLK_PERIOD);
      $display("timeout: the random operations did not complete in time");
      $display("Regression failed");
      $fatal(1, "watchdog expired");
   end

   // --------------------------------------------------
   // checking helpers
   // --------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got == exp)
      else
      begin
         $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
         $display("Regression failed");
         $fatal(1, "first mismatch ends the run");
      end
   endtask

   function automatic logic [31:0] expected_status();
      logic [31:0] st;
      st               = '0;
      st[ST_ROB_FULL]  = (rob_q.size() == ROB_DEPTH);
      st[ST_ROB_EMPTY] = (rob_q.size() == 0);
      st[ST_KEY_FULL]  = (key_q.size() == KEY_FIFO_DEPTH);
      st[ST_KEY_EMPTY] = (key_q.size() == 0);
      st[ST_ROB_OVF]   = rob_ovf_m;
      st[ST_KEY_OVF]   = key_ovf_m;
      st[11:8]         = 4'(rob_q.size());
      return st;
   endfunction

   // both queue heads against the model
   task automatic compare_heads();
      cmd_word_u head;
      check_value("rob_valid", 32'(rob_q.size() != 0), 32'(rob_valid));
      check_value("key_valid", 32'(key_q.size() != 0), 32'(key_valid));
      if (rob_q.size() != 0)
      begin
         head = rob_q[0];
         check_value("poly_id", 32'(pid_q[0]), 32'(poly_id));
         check_value("opcode", 32'(head.rob.opcode), 32'(opcode));
         check_value("intt_id", 32'(head.rob.intt_id), 32'(intt_id));
         check_value("init_value", 32'(head.rob.init_value), 32'(init_value));
         check_value("subs_factor", 32'(head.rob.subs_factor), 32'(subs_factor));
         check_value("bound1", 32'(bound1_tab[head.rob.gate]), 32'(bound1));
         check_value("bound2", 32'(bound2_tab[head.rob.gate]), 32'(bound2));
      end
      if (key_q.size() != 0)
      begin
         head = key_q[0];
         check_value("key_opcode", 32'(head.key.opcode), 32'(key_opcode));
         check_value("key_base_addr", 32'(head.key.base_addr), 32'(key_base_addr));
      end
   endtask

   // --------------------------------------------------
   // one clock: sample at the falling edge, update the model
   // at the rising edge, drive the ready and finish strobes just after it
   // --------------------------------------------------
   task automatic step_cycle();
      logic      push_rob;
      logic      push_key;
      logic      pop_rob;
      logic      pop_key;
      logic      set_rob_ovf;
      logic      set_key_ovf;
      logic      clr_ovf;
      cmd_word_u wr_word;
      @(negedge clk);
      compare_heads();
      check_value("awready", 32'(awvalid && wvalid && !b_pending), 32'(awready));
      check_value("wready", 32'(awvalid && wvalid && !b_pending), 32'(wready));
      check_value("arready", 32'(arvalid && !r_pending), 32'(arready));
      check_value("bvalid", 32'(b_pending), 32'(bvalid));
      check_value("rvalid", 32'(r_pending), 32'(rvalid));
      wr_hs = awvalid && awready && wvalid && wready;
      rd_hs = arvalid && arready;
      b_hs  = bvalid && bready;
      r_hs  = rvalid && rready;
      if (b_hs)
         check_value("bresp", 32'(exp_bresp), 32'(bresp));
      if (r_hs)
      begin
         check_value("rdata", exp_rdata, rdata);
         check_value("rresp", 32'(exp_rresp), 32'(rresp));
      end
      wr_word     = wdata;
      push_rob    = wr_hs && awaddr[7:0] == REG_ROB_CMD && rob_q.size() < ROB_DEPTH;
      set_rob_ovf = wr_hs && awaddr[7:0] == REG_ROB_CMD && rob_q.size() == ROB_DEPTH;
      push_key    = wr_hs && awaddr[7:0] == REG_KEY_CMD && key_q.size() < KEY_FIFO_DEPTH;
      set_key_ovf = wr_hs && awaddr[7:0] == REG_KEY_CMD && key_q.size() == KEY_FIFO_DEPTH;
      pop_rob     = ntt_rd_finish && rob_q.size() > 0;
      pop_key     = key_rd_finish && key_q.size() > 0;
      clr_ovf     = rd_hs && araddr[7:0] == REG_STATUS;
      if (wr_hs)
         exp_bresp = (awaddr[7:0] == REG_ROB_CMD || awaddr[7:0] == REG_KEY_CMD) ?
                     RESP_OKAY : RESP_SLVERR;
      if (rd_hs)
      begin
         case (araddr[7:0])
            REG_STATUS:
            begin
               exp_rdata = expected_status();
               exp_rresp = RESP_OKAY;
            end
            REG_ID:
            begin
               exp_rdata = OCL_ID;
               exp_rresp = RESP_OKAY;
            end
            default:
            begin
               exp_rdata = '0;
               exp_rresp = RESP_SLVERR;
            end
         endcase
      end
      @(posedge clk);
      if (pop_rob)
      begin
         rob_q.delete(0);
         pid_q.delete(0);
      end
      if (pop_key)
         key_q.delete(0);
      if (push_rob)
      begin
         rob_q.push_back(wr_word);
         pid_q.push_back(model_pid);
         model_pid = model_pid + 3'd1;
      end
      if (push_key)
         key_q.push_back(wr_word);
      // a read clears the sticky bits, a new overflow wins
      if (clr_ovf)
      begin
         rob_ovf_m = 1'b0;
         key_ovf_m = 1'b0;
      end
      if (set_rob_ovf)
         rob_ovf_m = 1'b1;
      if (set_key_ovf)
         key_ovf_m = 1'b1;
      if (wr_hs)
         b_pending = 1'b1;
      else if (b_hs)
         b_pending = 1'b0;
      if (rd_hs)
         r_pending = 1'b1;
      else if (r_hs)
         r_pending = 1'b0;
      #1;
      bready = ($urandom % 4) != 0;
      rready = ($urandom % 4) != 0;
      // finish pulses also land on empty queues
      ntt_rd_finish = ($urandom % 8) < pop_thresh;
      key_rd_finish = ($urandom % 8) < pop_thresh;
   endtask

   // --------------------------------------------------
   // host transactions
   // --------------------------------------------------
   // responses come back in step_cycle, so the next request
   // may already wait while one is still pending
   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'($urandom);
      step_cycle();
      while (!wr_hs)
         step_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr);
      arvalid = 1'b1;
      araddr  = addr;
      step_cycle();
      while (!rd_hs)
         step_cycle();
      arvalid = 1'b0;
   endtask

   // write and status read accepted on the same edge
   task automatic write_with_status_read(input logic [31:0] addr, input logic [31:0] data);
      logic wr_done;
      logic rd_done;
      while (b_pending || r_pending)
         step_cycle();
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'($urandom);
      arvalid = 1'b1;
      araddr  = {24'h0, REG_STATUS};
      wr_done = 1'b0;
      rd_done = 1'b0;
      while (!(wr_done && rd_done))
      begin
         step_cycle();
         if (wr_hs)
         begin
            wr_done = 1'b1;
            awvalid = 1'b0;
            wvalid  = 1'b0;
         end
         if (rd_hs)
         begin
            rd_done = 1'b1;
            arvalid = 1'b0;
         end
      end
   endtask

   task automatic run_random_ops();
      int sel;
      int sub;
      for (int i = 0; i < N_OPS; i++)
      begin
         // slow consumers now and then, so both queues fill up
         if ((i % 100) == 0)
            pop_thresh = int'($urandom % 8);
         sel = int'($urandom % 16);
         if (sel < 6)
            axi_write({24'h0, REG_ROB_CMD}, $urandom);
         else if (sel < 10)
            axi_write({24'h0, REG_KEY_CMD}, $urandom);
         else if (sel < 13)
            axi_read({24'h0, REG_STATUS});
         else if (sel == 13)
            axi_read({24'h0, REG_ID});
         else if (sel == 14)
            axi_write(32'(8'h08 + 4 * ($urandom % 6)), $urandom);
         else
         begin
            sub = int'($urandom % 4);
            if (sub == 0)
               axi_read({24'h0, REG_ROB_CMD});
            else if (sub == 1)
               axi_read(32'(8'h10 + 4 * ($urandom % 4)));
            else if (sub == 2)
               write_with_status_read({24'h0, REG_ROB_CMD}, $urandom);
            else
               write_with_status_read({24'h0, REG_KEY_CMD}, $urandom);
         end
      end
   endtask

   initial
   begin
      void'($urandom(32'hcb28));
      pipe_rst_n    = 1'b0;
      awvalid       = 1'b0;
      awaddr        = '0;
      wvalid        = 1'b0;
      wdata         = '0;
      wstrb         = '0;
      bready        = 1'b0;
      arvalid       = 1'b0;
      araddr        = '0;
      rready        = 1'b0;
      ntt_rd_finish = 1'b0;
      key_rd_finish = 1'b0;
      model_pid     = '0;
      rob_ovf_m     = 1'b0;
      key_ovf_m     = 1'b0;
      b_pending     = 1'b0;
      r_pending     = 1'b0;
      exp_bresp     = RESP_OKAY;
      exp_rdata     = '0;
      exp_rresp     = RESP_OKAY;
      pop_thresh    = 4;
      repeat (4) @(posedge clk);
      #1;
      pipe_rst_n = 1'b1;
      // first status read right after reset
      axi_read({24'h0, REG_STATUS});
      run_random_ops();
      axi_read({24'h0, REG_STATUS});
      // let the last responses arrive
      while (b_pending || r_pending)
         step_cycle();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* source/ocl_cmd_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ocl_cmd_top (
   input  logic                                   clk,
   input  logic                                   pipe_rst_n,
   // axi-lite from the host
   input  logic                                   awvalid,
   input  logic [31:0]                            awaddr,
   output logic                                   awready,
   input  logic                                   wvalid,
   input  logic [31:0]                            wdata,
   input  logic [3:0]                             wstrb,
   output logic                                   wready,
   output logic                                   bvalid,
   output logic [1:0]                             bresp,
   input  logic                                   bready,
   input  logic                                   arvalid,
   input  logic [31:0]                            araddr,
   output logic                                   arready,
   output logic                                   rvalid,
   output logic [31:0]                            rdata,
   output logic [1:0]                             rresp,
   input  logic                                   rready,
   // ntt read port
   output logic                                   rob_valid,
   output logic [ocl_cmd_pkg::POLY_ID_WIDTH-1:0]  poly_id,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]   opcode,
   output logic [ocl_cmd_pkg::INTT_ID_WIDTH-1:0]  intt_id,
   output logic [ocl_cmd_pkg::LWE_BIT_WIDTH-1:0]  init_value,
   output logic [ocl_cmd_pkg::SUBS_WIDTH-1:0]     subs_factor,
   output logic [ocl_cmd_pkg::BOUND_WIDTH-1:0]    bound1,
   output logic [ocl_cmd_pkg::BOUND_WIDTH-1:0]    bound2,
   input  logic                                   ntt_rd_finish,
   // key-load read port
   output logic                                   key_valid,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]   key_opcode,
   output logic [ocl_cmd_pkg::KEY_ADDR_WIDTH-1:0] key_base_addr,
   input  logic                                   key_rd_finish
);

   import ocl_cmd_pkg::*;

   logic                      rob_wr_en;
   logic [OPCODE_WIDTH-1:0]   rob_opcode;
   logic [GATE_WIDTH-1:0]     rob_gate;
   logic [INTT_ID_WIDTH-1:0]  rob_intt_id;
   logic [LWE_BIT_WIDTH-1:0]  rob_init_value;
   logic [SUBS_WIDTH-1:0]     rob_subs_factor;
   logic                      rob_full;
   logic [ROB_PTR_WIDTH:0]    rob_count;
   logic                      key_wr_en;
   logic [OPCODE_WIDTH-1:0]   key_opcode_in;
   logic [KEY_ADDR_WIDTH-1:0] key_base_addr_in;
   logic                      key_full;
   logic                      key_empty;

   // --------------------------------------------------
   // register slave
   // --------------------------------------------------
   ocl_slave u_ocl_slave (
      .clk              (clk),
      .pipe_rst_n       (pipe_rst_n),
      .awvalid          (awvalid),
      .awaddr           (awaddr),
      .awready          (awready),
      .wvalid           (wvalid),
      .wdata            (wdata),
      .wstrb            (wstrb),
      .wready           (wready),
      .bvalid           (bvalid),
      .bresp            (bresp),
      .bready           (bready),
      .arvalid          (arvalid),
      .araddr           (araddr),
      .arready          (arready),
      .rvalid           (rvalid),
      .rdata            (rdata),
      .rresp            (rresp),
      .rready           (rready),
      .rob_full         (rob_full),
      .rob_count        (rob_count),
      .key_full         (key_full),
      .key_empty        (key_empty),
      .rob_wr_en        (rob_wr_en),
      .rob_opcode       (rob_opcode),
      .rob_gate         (rob_gate),
      .rob_intt_id      (rob_intt_id),
      .rob_init_value   (rob_init_value),
      .rob_subs_factor  (rob_subs_factor),
      .key_wr_en        (key_wr_en),
      .key_opcode_in    (key_opcode_in),
      .key_base_addr_in (key_base_addr_in)
   );

   // --------------------------------------------------
   // command queues
   // --------------------------------------------------
   rob u_rob (
      .clk             (clk),
      .pipe_rst_n      (pipe_rst_n),
      .wr_en           (rob_wr_en),
      .opcode_in       (rob_opcode),
      .gate_in         (rob_gate),
      .intt_id_in      (rob_intt_id),
      .init_value_in   (rob_init_value),
      .subs_factor_in  (rob_subs_factor),
      .rd_finish       (ntt_rd_finish),
      .rob_full        (rob_full),
      .rob_count       (rob_count),
      .rob_valid       (rob_valid),
      .poly_id_out     (poly_id),
      .opcode_out      (opcode),
      .intt_id_out     (intt_id),
      .init_value_out  (init_value),
      .subs_factor_out (subs_factor),
      .bound1_out      (bound1),
      .bound2_out      (bound2)
   );

   key_inst_fifo u_key_fifo (
      .clk           (clk),
      .pipe_rst_n    (pipe_rst_n),
      .wr_en         (key_wr_en),
      .opcode_in     (key_opcode_in),
      .base_addr_in  (key_base_addr_in),
      .rd_finish     (key_rd_finish),
      .key_full      (key_full),
      .key_empty     (key_empty),
      .opcode_out    (key_opcode),
      .base_addr_out (key_base_addr)
   );

   assign key_valid = !key_empty;

endmodule

`default_nettype wire

/* source/key_inst_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module key_inst_fifo (
   input  logic                                   clk,
   input  logic                                   pipe_rst_n,
   input  logic                                   wr_en,
   input  logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]   opcode_in,
   input  logic [ocl_cmd_pkg::KEY_ADDR_WIDTH-1:0] base_addr_in,
   input  logic                                   rd_finish,
   output logic                                   key_full,
   output logic                                   key_empty,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]   opcode_out,
   output logic [ocl_cmd_pkg::KEY_ADDR_WIDTH-1:0] base_addr_out
);

   import ocl_cmd_pkg::*;

   logic [OPCODE_WIDTH-1:0]   opcode_mem    [KEY_FIFO_DEPTH];
   logic [KEY_ADDR_WIDTH-1:0] base_addr_mem [KEY_FIFO_DEPTH];
   logic [KEY_PTR_WIDTH-1:0]  wr_ptr;
   logic [KEY_PTR_WIDTH-1:0]  rd_ptr;
   logic [KEY_PTR_WIDTH:0]    count;
   logic                      pop;

   assign key_empty = (count == '0);
   assign key_full  = (count == (KEY_PTR_WIDTH + 1)'(KEY_FIFO_DEPTH));
   assign pop       = rd_finish && !key_empty;

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         opcode_mem[wr_ptr]    <= opcode_in;
         base_addr_mem[wr_ptr] <= base_addr_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !pop)
            count <= count + 1'b1;
         else if (pop && !wr_en)
            count <= count - 1'b1;
      end
   end

   // head shown without a register stage
   assign opcode_out    = opcode_mem[rd_ptr];
   assign base_addr_out = base_addr_mem[rd_ptr];

endmodule

`default_nettype wire

/* source/rob.sv */
`timescale 1ns/1ns
`default_nettype none

module rob (
   input  logic                                  clk,
   input  logic                                  pipe_rst_n,
   // push side
   input  logic                                  wr_en,
   input  logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]  opcode_in,
   input  logic [ocl_cmd_pkg::GATE_WIDTH-1:0]    gate_in,
   input  logic [ocl_cmd_pkg::INTT_ID_WIDTH-1:0] intt_id_in,
   input  logic [ocl_cmd_pkg::LWE_BIT_WIDTH-1:0] init_value_in,
   input  logic [ocl_cmd_pkg::SUBS_WIDTH-1:0]    subs_factor_in,
   // ntt consumer
   input  logic                                  rd_finish,
   output logic                                  rob_full,
   output logic [ocl_cmd_pkg::ROB_PTR_WIDTH:0]   rob_count,
   output logic                                  rob_valid,
   output logic [ocl_cmd_pkg::POLY_ID_WIDTH-1:0] poly_id_out,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]  opcode_out,
   output logic [ocl_cmd_pkg::INTT_ID_WIDTH-1:0] intt_id_out,
   output logic [ocl_cmd_pkg::LWE_BIT_WIDTH-1:0] init_value_out,
   output logic [ocl_cmd_pkg::SUBS_WIDTH-1:0]    subs_factor_out,
   output logic [ocl_cmd_pkg::BOUND_WIDTH-1:0]   bound1_out,
   output logic [ocl_cmd_pkg::BOUND_WIDTH-1:0]   bound2_out
);

   import ocl_cmd_pkg::*;

   logic [OPCODE_WIDTH-1:0]  opcode_mem      [ROB_DEPTH];
   logic [GATE_WIDTH-1:0]    gate_mem        [ROB_DEPTH];
   logic [INTT_ID_WIDTH-1:0] intt_id_mem     [ROB_DEPTH];
   logic [LWE_BIT_WIDTH-1:0] init_value_mem  [ROB_DEPTH];
   logic [SUBS_WIDTH-1:0]    subs_factor_mem [ROB_DEPTH];
   logic [POLY_ID_WIDTH-1:0] poly_id_mem     [ROB_DEPTH];
   logic [ROB_PTR_WIDTH-1:0] wr_ptr;
   logic [ROB_PTR_WIDTH-1:0] rd_ptr;
   logic [POLY_ID_WIDTH-1:0] poly_cnt;
   logic                     pop;

   assign rob_valid = (rob_count != '0);
   assign rob_full  = (rob_count == (ROB_PTR_WIDTH + 1)'(ROB_DEPTH));
   // finish on an empty buffer is ignored
   assign pop       = rd_finish && rob_valid;

   // --------------------------------------------------
   // entry storage
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         opcode_mem[wr_ptr]      <= opcode_in;
         gate_mem[wr_ptr]        <= gate_in;
         intt_id_mem[wr_ptr]     <= intt_id_in;
         init_value_mem[wr_ptr]  <= init_value_in;
         subs_factor_mem[wr_ptr] <= subs_factor_in;
         poly_id_mem[wr_ptr]     <= poly_cnt;
      end
   end

   // pointers wrap with the 3-bit width, as does the poly id
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         poly_cnt  <= '0;
         rob_count <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr   <= wr_ptr + 1'b1;
            poly_cnt <= poly_cnt + 1'b1;
         end
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !pop)
            rob_count <= rob_count + 1'b1;
         else if (pop && !wr_en)
            rob_count <= rob_count - 1'b1;
      end
   end

   // --------------------------------------------------
   // head entry and bound lookup
   // --------------------------------------------------
   assign poly_id_out     = poly_id_mem[rd_ptr];
   assign opcode_out      = opcode_mem[rd_ptr];
   assign intt_id_out     = intt_id_mem[rd_ptr];
   assign init_value_out  = init_value_mem[rd_ptr];
   assign subs_factor_out = subs_factor_mem[rd_ptr];
   assign bound1_out      = GATE_BOUND1[gate_mem[rd_ptr]];
   assign bound2_out      = GATE_BOUND2[gate_mem[rd_ptr]];

endmodule

`default_nettype wire

/* source/ocl_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module ocl_slave (
   input  logic                                     clk,
   input  logic                                     pipe_rst_n,
   // axi-lite write
   input  logic                                     awvalid,
   input  logic [31:0]                              awaddr,
   output logic                                     awready,
   input  logic                                     wvalid,
   input  logic [31:0]                              wdata,
   input  logic [3:0]                               wstrb,
   output logic                                     wready,
   output logic                                     bvalid,
   output logic [1:0]                               bresp,
   input  logic                                     bready,
   // axi-lite read
   input  logic                                     arvalid,
   input  logic [31:0]                              araddr,
   output logic                                     arready,
   output logic                                     rvalid,
   output logic [31:0]                              rdata,
   output logic [1:0]                               rresp,
   input  logic                                     rready,
   // queue levels
   input  logic                                     rob_full,
   input  logic [ocl_cmd_pkg::ROB_PTR_WIDTH:0]      rob_count,
   input  logic                                     key_full,
   input  logic                                     key_empty,
   // rob push
   output logic                                     rob_wr_en,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]     rob_opcode,
   output logic [ocl_cmd_pkg::GATE_WIDTH-1:0]       rob_gate,
   output logic [ocl_cmd_pkg::INTT_ID_WIDTH-1:0]    rob_intt_id,
   output logic [ocl_cmd_pkg::LWE_BIT_WIDTH-1:0]    rob_init_value,
   output logic [ocl_cmd_pkg::SUBS_WIDTH-1:0]       rob_subs_factor,
   // key-load push
   output logic                                     key_wr_en,
   output logic [ocl_cmd_pkg::OPCODE_WIDTH-1:0]     key_opcode_in,
   output logic [ocl_cmd_pkg::KEY_ADDR_WIDTH-1:0]   key_base_addr_in
);

   import ocl_cmd_pkg::*;

   cmd_word_u   cmd_word;
   logic        wr_fire;
   logic        wr_rob_sel;
   logic        wr_key_sel;
   logic        rob_ovf;
   logic        key_ovf;
   logic        rob_ovf_set;
   logic        key_ovf_set;
   logic        rd_fire;
   logic        status_rd;
   logic [31:0] status_word;

   // --------------------------------------------------
   // write channel
   // --------------------------------------------------
   // aw and w taken together, stalled while a response waits
   assign wr_fire = awvalid && wvalid && !bvalid;
   assign awready = wr_fire;
   assign wready  = wr_fire;

   // wstrb is not decoded, every command is a full word
   assign wr_rob_sel = (awaddr[7:0] == REG_ROB_CMD);
   assign wr_key_sel = (awaddr[7:0] == REG_KEY_CMD);
   assign cmd_word   = wdata;

   // a full queue drops the push and flags overflow instead
   assign rob_wr_en   = wr_fire && wr_rob_sel && !rob_full;
   assign key_wr_en   = wr_fire && wr_key_sel && !key_full;
   assign rob_ovf_set = wr_fire && wr_rob_sel && rob_full;
   assign key_ovf_set = wr_fire && wr_key_sel && key_full;

   assign rob_opcode       = cmd_word.rob.opcode;
   assign rob_gate         = cmd_word.rob.gate;
   assign rob_intt_id      = cmd_word.rob.intt_id;
   assign rob_init_value   = cmd_word.rob.init_value;
   assign rob_subs_factor  = cmd_word.rob.subs_factor;
   assign key_opcode_in    = cmd_word.key.opcode;
   assign key_base_addr_in = cmd_word.key.base_addr;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
         bvalid <= 1'b0;
      else if (wr_fire)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire)
         bresp <= (wr_rob_sel || wr_key_sel) ? RESP_OKAY : RESP_SLVERR;
   end

   // --------------------------------------------------
   // read channel and status
   // --------------------------------------------------
   assign rd_fire   = arvalid && !rvalid;
   assign arready   = rd_fire;
   assign status_rd = rd_fire && (araddr[7:0] == REG_STATUS);

   always_comb
   begin
      status_word               = '0;
      status_word[ST_ROB_FULL]  = rob_full;
      status_word[ST_ROB_EMPTY] = (rob_count == '0);
      status_word[ST_KEY_FULL]  = key_full;
      status_word[ST_KEY_EMPTY] = key_empty;
      status_word[ST_ROB_OVF]   = rob_ovf;
      status_word[ST_KEY_OVF]   = key_ovf;
      status_word[11:8]         = rob_count;
   end

   // sticky overflow, cleared by a status read unless set again
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         rob_ovf <= 1'b0;
         key_ovf <= 1'b0;
      end
      else
      begin
         rob_ovf <= rob_ovf_set || (rob_ovf && !status_rd);
         key_ovf <= key_ovf_set || (key_ovf && !status_rd);
      end
   end

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
         rvalid <= 1'b0;
      else if (rd_fire)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_fire)
      begin
         case (araddr[7:0])
            REG_STATUS:
            begin
               rdata <= status_word;
               rresp <= RESP_OKAY;
            end
            REG_ID:
            begin
               rdata <= OCL_ID;
               rresp <= RESP_OKAY;
            end
            default:
            begin
               rdata <= '0;
               rresp <= RESP_SLVERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/ocl_cmd_pkg.sv */
`default_nettype none

package ocl_cmd_pkg;

   // --------------------------------------------------
   // field widths and queue depths
   // --------------------------------------------------
   localparam int OPCODE_WIDTH   = 4;
   localparam int GATE_WIDTH     = 3;
   localparam int INTT_ID_WIDTH  = 1;
   localparam int LWE_BIT_WIDTH  = 16;
   localparam int SUBS_WIDTH     = 4;
   localparam int KEY_ADDR_WIDTH = 28;
   localparam int BOUND_WIDTH    = 16;
   localparam int POLY_ID_WIDTH  = 3;

   localparam int ROB_DEPTH      = 8;
   localparam int KEY_FIFO_DEPTH = 8;
   localparam int ROB_PTR_WIDTH  = 3;
   localparam int KEY_PTR_WIDTH  = 3;

   // iNTT bounds per gate, gate 7 leftmost
   localparam logic [7:0][BOUND_WIDTH-1:0] GATE_BOUND1 = {
      16'h3c00, 16'h3400, 16'h2c00, 16'h2400, 16'h1c00, 16'h1400, 16'h0c00, 16'h0400
   };
   localparam logic [7:0][BOUND_WIDTH-1:0] GATE_BOUND2 = {
      16'h7e00, 16'h7600, 16'h6e00, 16'h6600, 16'h5e00, 16'h5600, 16'h4e00, 16'h4600
   };

   // --------------------------------------------------
   // register map, low address byte
   // --------------------------------------------------
   localparam logic [7:0]  REG_ROB_CMD = 8'h00;
   localparam logic [7:0]  REG_KEY_CMD = 8'h04;
   localparam logic [7:0]  REG_STATUS  = 8'h08;
   localparam logic [7:0]  REG_ID      = 8'h0c;
   localparam logic [31:0] OCL_ID      = 32'hfe0c_0d01;

   // status word bits, rob occupancy in 11:8
   localparam int ST_ROB_FULL  = 0;
   localparam int ST_ROB_EMPTY = 1;
   localparam int ST_KEY_FULL  = 2;
   localparam int ST_KEY_EMPTY = 3;
   localparam int ST_ROB_OVF   = 4;
   localparam int ST_KEY_OVF   = 5;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // one host command word, read as a rob or a key-load command
   typedef union packed {
      struct packed {
         logic [OPCODE_WIDTH-1:0]  opcode;
         logic [GATE_WIDTH-1:0]    gate;
         logic [INTT_ID_WIDTH-1:0] intt_id;
         logic [LWE_BIT_WIDTH-1:0] init_value;
         logic [SUBS_WIDTH-1:0]    subs_factor;
         logic [3:0]               pad;
      } rob;
      struct packed {
         logic [OPCODE_WIDTH-1:0]   opcode;
         logic [KEY_ADDR_WIDTH-1:0] base_addr;
      } key;
   } cmd_word_u;

endpackage

`default_nettype wire
